//--- common/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

  typedef logic [31:0] word_t;      // Data word or byte address.
  typedef logic [4:0]  reg_addr_t;  // Index into the register file.
  typedef logic [4:0]  shamt_t;     // Shift amount field of R-type instructions.
  typedef logic [15:0] imm_t;       // Immediate field of I-type instructions.

  // Primary opcodes in bits 31:26 that the core decodes.
  typedef enum logic [5:0] {
    op_special = 6'h00,  // R-type, the operation is in funct.
    op_j       = 6'h02,
    op_jal     = 6'h03,
    op_beq     = 6'h04,
    op_bne     = 6'h05,
    op_addiu   = 6'h09,
    op_slti    = 6'h0a,
    op_sltiu   = 6'h0b,
    op_andi    = 6'h0c,
    op_ori     = 6'h0d,
    op_xori    = 6'h0e,
    op_lui     = 6'h0f,
    op_lw      = 6'h23,
    op_sw      = 6'h2b
  } opcode_e;

  // Function codes in bits 5:0 when the opcode is op_special.
  typedef enum logic [5:0] {
    fn_sll  = 6'h00,
    fn_srl  = 6'h02,
    fn_jr   = 6'h08,
    fn_addu = 6'h21,
    fn_subu = 6'h23,
    fn_and  = 6'h24,
    fn_or   = 6'h25,
    fn_xor  = 6'h26,
    fn_slt  = 6'h2a,
    fn_sltu = 6'h2b
  } funct_e;

  localparam word_t reset_vector = 32'hBFC00000;  // Boot ROM entry of the MIPS memory map.

endpackage

`default_nettype wire

//--- common/mips_ctrl_pkg.sv
`default_nettype none

package mips_ctrl_pkg;

  // Operation selected for the ALU.
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sltu,
    alu_sll,
    alu_srl,
    alu_lui
  } alu_op_e;

  // Where the next control transfer comes from. Branches still need the
  // register comparison, which the datapath does.
  typedef enum logic [1:0] {
    pc_seq,
    pc_branch,
    pc_jump,
    pc_jump_reg
  } pc_src_e;

  // Source of the value written back to the register file.
  typedef enum logic [1:0] {
    wb_alu,
    wb_mem,
    wb_link
  } wb_src_e;

endpackage

`default_nettype wire

//--- datapath/mips_alu.sv
`timescale 1ns/1ns
`default_nettype none

module mips_alu (
  input  mips_ctrl_pkg::alu_op_e op,
  input  mips_isa_pkg::word_t    a,
  input  mips_isa_pkg::word_t    b,
  input  mips_isa_pkg::shamt_t   shamt,
  output mips_isa_pkg::word_t    y
);

  always_comb begin
    case (op)
      mips_ctrl_pkg::alu_add: y = a + b;
      mips_ctrl_pkg::alu_sub: y = a - b;
      mips_ctrl_pkg::alu_and: y = a & b;
      mips_ctrl_pkg::alu_or:  y = a | b;
      mips_ctrl_pkg::alu_xor: y = a ^ b;
      mips_ctrl_pkg::alu_slt: begin
        y = {31'b0, $signed(a) < $signed(b)};  // Signed compare gives 0 or 1.
      end
      mips_ctrl_pkg::alu_sltu: begin
        y = {31'b0, a < b};
      end
      // Shifts act on the rt operand, as MIPS defines them.
      mips_ctrl_pkg::alu_sll: y = b << shamt;
      mips_ctrl_pkg::alu_srl: y = b >> shamt;
      mips_ctrl_pkg::alu_lui: y = {b[15:0], 16'b0};
      default:                y = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- datapath/mips_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module mips_regfile (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     we,
  input  mips_isa_pkg::reg_addr_t ra1,
  input  mips_isa_pkg::reg_addr_t ra2,
  input  mips_isa_pkg::reg_addr_t wa,
  input  mips_isa_pkg::word_t     wd,
  output mips_isa_pkg::word_t     rd1,
  output mips_isa_pkg::word_t     rd2,
  output mips_isa_pkg::word_t     v0,
  output mips_isa_pkg::word_t     v3
);

  mips_isa_pkg::word_t regs [31:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wa != '0)) begin
      regs[wa] <= wd;  // Writes to $0 are dropped.
    end
  end

  assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

  // Result registers watched by the test environment.
  assign v0 = regs[2];
  assign v3 = regs[3];

endmodule

`default_nettype wire

//--- datapath/mips_datapath.sv
`timescale 1ns/1ns
`default_nettype none

module mips_datapath #(
  parameter mips_isa_pkg::word_t reset_addr = mips_isa_pkg::reset_vector
) (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     clk_enable,
  input  wire                     run,
  input  mips_isa_pkg::word_t     instr,
  input  mips_ctrl_pkg::alu_op_e  alu_op,
  input  wire                     alu_src_imm,
  input  wire                     imm_zero_ext,
  input  mips_isa_pkg::reg_addr_t reg_dst,
  input  mips_ctrl_pkg::wb_src_e  wb_src,
  input  wire                     reg_write,
  input  mips_ctrl_pkg::pc_src_e  pc_src,
  input  wire                     branch_ne,
  output mips_isa_pkg::word_t     pc,
  output mips_isa_pkg::word_t     mem_addr,
  output mips_isa_pkg::word_t     mem_wdata,
  input  mips_isa_pkg::word_t     mem_rdata,
  output mips_isa_pkg::word_t     register_v0,
  output mips_isa_pkg::word_t     register_v3
);

  mips_isa_pkg::imm_t imm;
  mips_isa_pkg::word_t imm_ext, pc_plus4, branch_off, target, pending_target;
  mips_isa_pkg::word_t rs_val, rt_val, alu_b, alu_y, wb_data;
  logic zero;
  logic taken;
  logic pending;
  logic step;

  assign imm        = instr[15:0];
  assign imm_ext    = imm_zero_ext ? {16'b0, imm} : {{16{imm[15]}}, imm};
  assign branch_off = {{14{imm[15]}}, imm, 2'b00};
  assign pc_plus4   = pc + 32'd4;
  assign alu_b      = alu_src_imm ? imm_ext : rt_val;
  assign zero       = (alu_y == '0);
  assign step       = clk_enable && run;

  assign mem_addr  = alu_y;
  assign mem_wdata = rt_val;

  always_comb begin
    taken  = 1'b0;
    target = pc_plus4 + branch_off;
    case (pc_src)
      mips_ctrl_pkg::pc_branch: taken = zero ^ branch_ne;
      mips_ctrl_pkg::pc_jump: begin
        taken  = 1'b1;
        target = {pc_plus4[31:28], instr[25:0], 2'b00};
      end
      mips_ctrl_pkg::pc_jump_reg: begin
        taken  = 1'b1;
        target = rs_val;
      end
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (wb_src)
      mips_ctrl_pkg::wb_mem:  wb_data = mem_rdata;
      mips_ctrl_pkg::wb_link: wb_data = pc_plus4 + 32'd4;  // Skips the delay slot.
      default:                wb_data = alu_y;
    endcase
  end

  // A taken transfer first lets the delay slot run, then the PC takes the target.
  always_ff @(posedge clk) begin
    if (rst) begin
      pc      <= reset_addr;
      pending <= 1'b0;
    end else if (step) begin
      pc      <= pending ? pending_target : pc_plus4;
      pending <= taken;
    end
  end

  always_ff @(posedge clk) begin
    if (step && taken) begin
      pending_target <= target;
    end
  end

  mips_regfile regfile_i (
    .clk (clk),
    .rst (rst),
    .we  (reg_write && step),
    .ra1 (instr[25:21]),
    .ra2 (instr[20:16]),
    .wa  (reg_dst),
    .wd  (wb_data),
    .rd1 (rs_val),
    .rd2 (rt_val),
    .v0  (register_v0),
    .v3  (register_v3)
  );

  mips_alu alu_i (
    .op    (alu_op),
    .a     (rs_val),
    .b     (alu_b),
    .shamt (instr[10:6]),
    .y     (alu_y)
  );

endmodule

`default_nettype wire

//--- controller/mips_controller.sv
`timescale 1ns/1ns
`default_nettype none

module mips_controller (
  input  mips_isa_pkg::word_t     instr,
  output mips_ctrl_pkg::alu_op_e  alu_op,
  output logic                    alu_src_imm,
  output logic                    imm_zero_ext,
  output mips_isa_pkg::reg_addr_t reg_dst,
  output mips_ctrl_pkg::wb_src_e  wb_src,
  output logic                    reg_write,
  output logic                    mem_write,
  output logic                    mem_read,
  output mips_ctrl_pkg::pc_src_e  pc_src,
  output logic                    branch_ne
);

  mips_isa_pkg::opcode_e   opcode;
  mips_isa_pkg::funct_e    funct;
  mips_isa_pkg::reg_addr_t rt;
  mips_isa_pkg::reg_addr_t rd;

  assign opcode = mips_isa_pkg::opcode_e'(instr[31:26]);
  assign funct  = mips_isa_pkg::funct_e'(instr[5:0]);
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];

  always_comb begin
    // Anything not matched below falls through as a no-op.
    alu_op       = mips_ctrl_pkg::alu_add;
    alu_src_imm  = 1'b0;
    imm_zero_ext = 1'b0;
    reg_dst      = rd;
    wb_src       = mips_ctrl_pkg::wb_alu;
    reg_write    = 1'b0;
    mem_write    = 1'b0;
    mem_read     = 1'b0;
    pc_src       = mips_ctrl_pkg::pc_seq;
    branch_ne    = 1'b0;
    case (opcode)
      mips_isa_pkg::op_special: begin
        reg_write = 1'b1;
        case (funct)
          mips_isa_pkg::fn_sll:  alu_op = mips_ctrl_pkg::alu_sll;
          mips_isa_pkg::fn_srl:  alu_op = mips_ctrl_pkg::alu_srl;
          mips_isa_pkg::fn_addu: alu_op = mips_ctrl_pkg::alu_add;
          mips_isa_pkg::fn_subu: alu_op = mips_ctrl_pkg::alu_sub;
          mips_isa_pkg::fn_and:  alu_op = mips_ctrl_pkg::alu_and;
          mips_isa_pkg::fn_or:   alu_op = mips_ctrl_pkg::alu_or;
          mips_isa_pkg::fn_xor:  alu_op = mips_ctrl_pkg::alu_xor;
          mips_isa_pkg::fn_slt:  alu_op = mips_ctrl_pkg::alu_slt;
          mips_isa_pkg::fn_sltu: alu_op = mips_ctrl_pkg::alu_sltu;
          mips_isa_pkg::fn_jr: begin
            reg_write = 1'b0;
            pc_src    = mips_ctrl_pkg::pc_jump_reg;
          end
          default: reg_write = 1'b0;
        endcase
      end
      mips_isa_pkg::op_j: pc_src = mips_ctrl_pkg::pc_jump;
      mips_isa_pkg::op_jal: begin
        pc_src    = mips_ctrl_pkg::pc_jump;
        reg_dst   = 5'd31;  // Return address goes to ra.
        wb_src    = mips_ctrl_pkg::wb_link;
        reg_write = 1'b1;
      end
      mips_isa_pkg::op_beq, mips_isa_pkg::op_bne: begin
        alu_op    = mips_ctrl_pkg::alu_sub;  // Zero result means rs equals rt.
        pc_src    = mips_ctrl_pkg::pc_branch;
        branch_ne = (opcode == mips_isa_pkg::op_bne);
      end
      mips_isa_pkg::op_lw: begin
        alu_src_imm = 1'b1;
        reg_dst     = rt;
        wb_src      = mips_ctrl_pkg::wb_mem;
        reg_write   = 1'b1;
        mem_read    = 1'b1;
      end
      mips_isa_pkg::op_sw: begin
        alu_src_imm = 1'b1;
        mem_write   = 1'b1;
      end
      default: begin
        // Remaining opcodes are the ALU immediates, all writing rt.
        alu_src_imm = 1'b1;
        reg_dst     = rt;
        reg_write   = 1'b1;
        case (opcode)
          mips_isa_pkg::op_addiu: alu_op = mips_ctrl_pkg::alu_add;
          mips_isa_pkg::op_slti:  alu_op = mips_ctrl_pkg::alu_slt;
          mips_isa_pkg::op_sltiu: alu_op = mips_ctrl_pkg::alu_sltu;
          mips_isa_pkg::op_lui:   alu_op = mips_ctrl_pkg::alu_lui;
          mips_isa_pkg::op_andi: begin
            alu_op       = mips_ctrl_pkg::alu_and;
            imm_zero_ext = 1'b1;
          end
          mips_isa_pkg::op_ori: begin
            alu_op       = mips_ctrl_pkg::alu_or;
            imm_zero_ext = 1'b1;
          end
          mips_isa_pkg::op_xori: begin
            alu_op       = mips_ctrl_pkg::alu_xor;
            imm_zero_ext = 1'b1;
          end
          default: reg_write = 1'b0;  // Unsupported opcode.
        endcase
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/mips_cpu_harvard.sv
`timescale 1ns/1ns
`default_nettype none

module mips_cpu_harvard #(
  parameter mips_isa_pkg::word_t reset_addr = mips_isa_pkg::reset_vector
) (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 clk_enable,
  output logic                active,
  output mips_isa_pkg::word_t register_v0,
  output mips_isa_pkg::word_t register_v3,
  output mips_isa_pkg::word_t instr_address,
  input  mips_isa_pkg::word_t instr_readdata,
  output mips_isa_pkg::word_t data_address,
  output logic                data_write,
  output logic                data_read,
  output mips_isa_pkg::word_t data_writedata,
  input  mips_isa_pkg::word_t data_readdata
);

  mips_ctrl_pkg::alu_op_e alu_op;
  mips_ctrl_pkg::wb_src_e wb_src;
  mips_ctrl_pkg::pc_src_e pc_src;
  mips_isa_pkg::reg_addr_t reg_dst;
  logic alu_src_imm;
  logic imm_zero_ext;
  logic reg_write;
  logic mem_write;
  logic mem_read;
  logic branch_ne;
  logic run;

  // The core stops as soon as the PC reaches 0, active follows one edge later.
  assign run = active && (instr_address != '0);

  assign data_write = mem_write && clk_enable && run;
  assign data_read  = mem_read && clk_enable && run;

  always_ff @(posedge clk) begin
    if (rst) begin
      active <= 1'b1;
    end else if (clk_enable) begin
      active <= (instr_address != '0);  // Halted once the PC has jumped to 0.
    end
  end

  mips_controller controller_i (
    .instr        (instr_readdata),
    .alu_op       (alu_op),
    .alu_src_imm  (alu_src_imm),
    .imm_zero_ext (imm_zero_ext),
    .reg_dst      (reg_dst),
    .wb_src       (wb_src),
    .reg_write    (reg_write),
    .mem_write    (mem_write),
    .mem_read     (mem_read),
    .pc_src       (pc_src),
    .branch_ne    (branch_ne)
  );

  mips_datapath #(
    .reset_addr (reset_addr)
  ) datapath_i (
    .clk          (clk),
    .rst          (rst),
    .clk_enable   (clk_enable),
    .run          (run),
    .instr        (instr_readdata),
    .alu_op       (alu_op),
    .alu_src_imm  (alu_src_imm),
    .imm_zero_ext (imm_zero_ext),
    .reg_dst      (reg_dst),
    .wb_src       (wb_src),
    .reg_write    (reg_write),
    .pc_src       (pc_src),
    .branch_ne    (branch_ne),
    .pc           (instr_address),
    .mem_addr     (data_address),
    .mem_wdata    (data_writedata),
    .mem_rdata    (data_readdata),
    .register_v0  (register_v0),
    .register_v3  (register_v3)
  );

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int half_period  = 2,  // 4 ns clock period.
  parameter int reset_cycles = 3
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;  // Released just after the edge, like every other input.
  end

endmodule

`default_nettype wire

//--- verif/mips_cpu_chk.sv
`timescale 1ns/1ns
`default_nettype none

module mips_cpu_chk (
  input wire                 clk,
  input wire                 rst,
  input wire                 clk_enable,
  input wire                 active,
  input wire                 data_write,
  input wire                 data_read,
  input mips_isa_pkg::word_t instr_address,
  input mips_isa_pkg::word_t register_v0,
  input mips_isa_pkg::word_t register_v3
);

  int failures = 0;  // Number of assertion failures so far.

  strobe_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(data_write && data_read))
    else begin
      $error("data_write and data_read are high in the same cycle");
      failures++;
    end

  // A disabled edge must leave the visible state untouched.
  stall_freezes: assert property (@(posedge clk) disable iff (rst)
    !clk_enable |=> $stable(instr_address) && $stable(register_v0) && $stable(register_v3))
    else begin
      $error("state changed on an edge with clk_enable low");
      failures++;
    end

  pc_aligned: assert property (@(posedge clk) disable iff (rst)
    instr_address[1:0] == 2'b00)
    else begin
      $error("instr_address is not word aligned");
      failures++;
    end

  active_after_reset: assert property (@(posedge clk) $fell(rst) |-> active)
    else begin
      $error("active is low right after reset");
      failures++;
    end

  halt_sticky: assert property (@(posedge clk) disable iff (rst)
    !active |=> !active)
    else begin
      $error("active rose again after the CPU halted");
      failures++;
    end

  halt_quiet: assert property (@(posedge clk) disable iff (rst)
    !active |-> !(data_write || data_read))
    else begin
      $error("data strobe while the CPU is halted");
      failures++;
    end

endmodule

`default_nettype wire

//--- verif/mips_cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mips_cpu_tb;

  localparam mips_isa_pkg::word_t reset_addr = 32'hBFC00000;
  localparam int max_cycles = 200;  // The program needs about 55 cycles with stalls.

  wire clk;
  wire rst;
  logic clk_enable;
  logic active;
  logic data_write;
  logic data_read;
  mips_isa_pkg::word_t register_v0, register_v3;
  mips_isa_pkg::word_t instr_address, instr_readdata, rom_offset;
  mips_isa_pkg::word_t data_address, data_writedata, data_readdata;
  mips_isa_pkg::word_t fill_word;
  mips_isa_pkg::word_t rom [0:63];
  mips_isa_pkg::word_t ram [0:63];
  logic [31:0] lcg_state;
  int value_errors;
  int other_errors;
  int cycles;

  tb_clock_gen clock_gen_i (
    .clk (clk),
    .rst (rst)
  );

  mips_cpu_harvard #(
    .reset_addr (reset_addr)
  ) mips_cpu_harvard_i (
    .clk            (clk),
    .rst            (rst),
    .clk_enable     (clk_enable),
    .active         (active),
    .register_v0    (register_v0),
    .register_v3    (register_v3),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_write     (data_write),
    .data_read      (data_read),
    .data_writedata (data_writedata),
    .data_readdata  (data_readdata)
  );

  bind mips_cpu_harvard mips_cpu_chk mips_cpu_chk_i (
    .clk           (clk),
    .rst           (rst),
    .clk_enable    (clk_enable),
    .active        (active),
    .data_write    (data_write),
    .data_read     (data_read),
    .instr_address (instr_address),
    .register_v0   (register_v0),
    .register_v3   (register_v3)
  );

  // Anything outside the ROM window reads as a store, which a halted CPU must ignore.
  assign rom_offset     = instr_address - reset_addr;
  assign instr_readdata = (rom_offset < 32'd256) ? rom[rom_offset[7:2]] : fill_word;
  // The RAM only answers a read request.
  assign data_readdata  = data_read ? ram[data_address[7:2]] : 32'hBAD0_BAD0;

  always @(posedge clk) begin
    if (data_write) begin
      ram[data_address[7:2]] <= data_writedata;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic mips_isa_pkg::word_t rom_addr(input int n);
    return reset_addr + 32'(n * 4);
  endfunction

  function automatic mips_isa_pkg::word_t r_type(input logic [5:0] funct,
      input logic [4:0] rd, input logic [4:0] rs, input logic [4:0] rt,
      input logic [4:0] shamt);
    return {6'h00, rs, rt, rd, shamt, funct};
  endfunction

  function automatic mips_isa_pkg::word_t i_type(input logic [5:0] op,
      input logic [4:0] rt, input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic mips_isa_pkg::word_t j_type(input logic [5:0] op,
      input mips_isa_pkg::word_t target);
    return {op, target[27:2]};
  endfunction

  task automatic check_word(input string name, input mips_isa_pkg::word_t got,
      input mips_isa_pkg::word_t expected);
    assert (got === expected) else begin
      value_errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
    end
  endtask

  task automatic load_program();
    fill_word = i_type(mips_isa_pkg::op_sw, 2, 0, 16'h0044);  // Would clobber ram[0x44].
    for (int i = 0; i < 64; i++) begin
      rom[i] = '0;
      ram[i] = 32'hDA7A0000 | 32'(i * 4);  // Each word holds its own byte address.
    end
    rom[0]  = i_type(mips_isa_pkg::op_lui, 8, 0, 16'h1234);
    rom[1]  = i_type(mips_isa_pkg::op_ori, 8, 8, 16'h5678);
    rom[2]  = i_type(mips_isa_pkg::op_addiu, 9, 0, 16'hFFFD);
    rom[3]  = r_type(mips_isa_pkg::fn_addu, 10, 8, 9, 0);
    rom[4]  = r_type(mips_isa_pkg::fn_subu, 11, 8, 9, 0);
    rom[5]  = r_type(mips_isa_pkg::fn_and, 12, 10, 11, 0);
    rom[6]  = r_type(mips_isa_pkg::fn_or, 13, 10, 11, 0);
    rom[7]  = r_type(mips_isa_pkg::fn_xor, 14, 12, 13, 0);
    rom[8]  = r_type(mips_isa_pkg::fn_sll, 15, 0, 14, 4);
    rom[9]  = r_type(mips_isa_pkg::fn_srl, 24, 0, 8, 8);
    rom[10] = i_type(mips_isa_pkg::op_andi, 25, 24, 16'hF0F0);
    rom[11] = i_type(mips_isa_pkg::op_xori, 25, 25, 16'h00FF);
    rom[12] = r_type(mips_isa_pkg::fn_slt, 16, 9, 0, 0);
    rom[13] = r_type(mips_isa_pkg::fn_sltu, 17, 9, 0, 0);
    rom[14] = i_type(mips_isa_pkg::op_slti, 18, 9, 16'hFFFE);
    rom[15] = r_type(mips_isa_pkg::fn_addu, 2, 15, 24, 0);
    rom[16] = r_type(mips_isa_pkg::fn_addu, 2, 2, 25, 0);
    rom[17] = r_type(mips_isa_pkg::fn_addu, 2, 2, 16, 0);
    rom[18] = r_type(mips_isa_pkg::fn_addu, 2, 2, 17, 0);
    rom[19] = r_type(mips_isa_pkg::fn_sll, 18, 0, 18, 8);
    rom[20] = r_type(mips_isa_pkg::fn_addu, 2, 2, 18, 0);
    rom[21] = i_type(mips_isa_pkg::op_addiu, 0, 0, 16'h0055);  // Must be lost.
    rom[22] = r_type(mips_isa_pkg::fn_addu, 3, 0, 0, 0);
    rom[23] = i_type(mips_isa_pkg::op_sw, 8, 0, 16'h0040);
    rom[24] = i_type(mips_isa_pkg::op_lw, 19, 0, 16'h0040);
    rom[25] = i_type(mips_isa_pkg::op_sw, 2, 0, 16'h0044);
    rom[26] = r_type(mips_isa_pkg::fn_addu, 2, 2, 19, 0);
    rom[27] = i_type(mips_isa_pkg::op_beq, 0, 0, 16'd2);  // Taken, lands on 30.
    rom[28] = i_type(mips_isa_pkg::op_addiu, 3, 3, 16'h0001);
    rom[29] = i_type(mips_isa_pkg::op_addiu, 3, 3, 16'h0100);
    rom[30] = i_type(mips_isa_pkg::op_bne, 0, 0, 16'd5);  // Not taken.
    rom[31] = i_type(mips_isa_pkg::op_addiu, 3, 3, 16'h0002);
    rom[32] = j_type(mips_isa_pkg::op_j, rom_addr(35));
    rom[33] = i_type(mips_isa_pkg::op_addiu, 3, 3, 16'h0004);
    rom[34] = i_type(mips_isa_pkg::op_addiu, 3, 3, 16'h0200);
    rom[35] = j_type(mips_isa_pkg::op_jal, rom_addr(38));
    rom[36] = i_type(mips_isa_pkg::op_addiu, 3, 3, 16'h0008);
    rom[37] = i_type(mips_isa_pkg::op_addiu, 3, 3, 16'h0400);
    rom[38] = i_type(mips_isa_pkg::op_sw, 31, 0, 16'h0048);
    rom[39] = r_type(mips_isa_pkg::fn_jr, 0, 0, 0, 0);
    rom[40] = i_type(mips_isa_pkg::op_addiu, 2, 2, 16'h0010);
    rom[41] = i_type(mips_isa_pkg::op_addiu, 3, 3, 16'h0800);  // Beyond the halt.
  endtask

  initial begin
    clk_enable = 1'b1;
    lcg_state  = 32'd79172;
    forever begin
      @(posedge clk);
      #1;
      lcg_state  = lcg_next(lcg_state);
      clk_enable = (lcg_state[17:16] != 2'b00);  // Low on about one cycle in four.
    end
  end

  initial begin
    mips_isa_pkg::word_t t0, t1, t2, t3, t8, v0_stored;
    value_errors = 0;
    other_errors = 0;
    cycles = 0;
    load_program();
    @(negedge rst);
    while (active && cycles < max_cycles) begin
      @(negedge clk);
      cycles++;
    end
    if (active) begin
      other_errors++;
      $display("Timeout: the CPU did not halt within %0d cycles", max_cycles);
    end else begin
      repeat (4) @(negedge clk);
      // Expected results, worked out from the instruction semantics.
      t0 = {16'h1234, 16'h0000} | 32'h0000_5678;
      t1 = 32'd0 - 32'd3;
      t2 = t0 + t1;
      t3 = t0 - t1;
      t8 = t0 >> 8;
      v0_stored = (((t2 & t3) ^ (t2 | t3)) << 4) + t8;
      v0_stored = v0_stored + ((t8 & 32'h0000_F0F0) ^ 32'h0000_00FF);
      v0_stored = v0_stored + {31'b0, $signed(t1) < 0} + {31'b0, t1 < 32'd0};
      v0_stored = v0_stored + ({31'b0, $signed(t1) < -32'sd2} << 8);
      check_word("instr_address", instr_address, 32'h0);
      check_word("register_v0", register_v0, v0_stored + t0 + 32'h10);
      check_word("register_v3", register_v3, 32'h1 + 32'h2 + 32'h4 + 32'h8);
      check_word("ram[0x40]", ram[16], t0);
      check_word("ram[0x44]", ram[17], v0_stored);
      check_word("ram[0x48]", ram[18], rom_addr(37));  // jal return address.
    end
    other_errors += mips_cpu_harvard_i.mips_cpu_chk_i.failures;
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
common/mips_isa_pkg.sv
common/mips_ctrl_pkg.sv
datapath/mips_alu.sv
datapath/mips_regfile.sv
datapath/mips_datapath.sv
controller/mips_controller.sv
verilog/mips_cpu_harvard.sv
verif/tb_clock_gen.sv
verif/mips_cpu_chk.sv
verif/mips_cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module mips_cpu_tb \
  -f filelist.f -o mips_cpu_sim &&
{ ./obj_dir/mips_cpu_sim > sim.log 2>&1 || true; } &&
cat sim.log &&
grep -q '^ALL CHECKS PASSED$' sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed, see sim.log"; exit 1; }
